/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* csr_checker.sv */
// CSR unit checker: reset and response handshake assertions
`timescale 1ns/1ps

module csr_checker
  import csr_pkg::*;
(
  input logic      CLK,
  input logic      nRST,
  input logic      req_ready,
  input logic      rsp_valid,
  input logic      rsp_ready,
  input csr_word_t rsp_rdata,
  input logic      rsp_illegal
);

  int fail_count = 0;

  // Nothing pending right out of reset
  reset_idle: assert property (@(posedge CLK) $rose(nRST) |-> !rsp_valid)
    else begin
      fail_count++;
      $error("rsp_valid high on the first edge after reset");
    end

  rsp_stable: assert property (@(posedge CLK) disable iff (!nRST)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_illegal)))
    else begin
      fail_count++;
      $error("response changed or dropped while stalled");
    end

  // Single response slot
  no_accept_stalled: assert property (@(posedge CLK) disable iff (!nRST)
      (rsp_valid && !rsp_ready) |-> !req_ready)
    else begin
      fail_count++;
      $error("req_ready high while a response waits");
    end

endmodule

bind csr_unit csr_checker i_checker (
  .CLK, .nRST, .req_ready, .rsp_valid, .rsp_ready, .rsp_rdata, .rsp_illegal
);

/* csr_decode.sv */
// CSR decode: maps the request address to a register select and checks access rights
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_decode
  import csr_pkg::*;
(
  input  csr_op_t     req_op,
  input  csr_addr_u   req_addr,
  input  priv_level_t req_priv,
  input  logic        cnt_en_cy,
  input  logic        cnt_en_ir,
  output csr_sel_t    sel,
  output logic        illegal
);

  logic ro_write;
  logic low_priv;
  logic unknown;
  logic mirror_en;
  logic cnt_denied;

  always_comb begin
    case (req_addr.raw)
      `CSR_ADDR_MSTATUS:       sel = SEL_MSTATUS;
      `CSR_ADDR_MIE:           sel = SEL_MIE;
      `CSR_ADDR_MTVEC:         sel = SEL_MTVEC;
      `CSR_ADDR_MCOUNTEREN:    sel = SEL_MCOUNTEREN;
      `CSR_ADDR_MCOUNTINHIBIT: sel = SEL_MCOUNTINHIBIT;
      `CSR_ADDR_MSCRATCH:      sel = SEL_MSCRATCH;
      `CSR_ADDR_MEPC:          sel = SEL_MEPC;
      `CSR_ADDR_MCAUSE:        sel = SEL_MCAUSE;
      `CSR_ADDR_MTVAL:         sel = SEL_MTVAL;
      `CSR_ADDR_MIP:           sel = SEL_MIP;
      `CSR_ADDR_MCYCLE:        sel = SEL_MCYCLE;
      `CSR_ADDR_MCYCLEH:       sel = SEL_MCYCLEH;
      `CSR_ADDR_MINSTRET:      sel = SEL_MINSTRET;
      `CSR_ADDR_MINSTRETH:     sel = SEL_MINSTRETH;
      `CSR_ADDR_CYCLE:         sel = SEL_CYCLE;
      `CSR_ADDR_CYCLEH:        sel = SEL_CYCLEH;
      `CSR_ADDR_INSTRET:       sel = SEL_INSTRET;
      `CSR_ADDR_INSTRETH:      sel = SEL_INSTRETH;
      `CSR_ADDR_MVENDORID:     sel = SEL_MVENDORID;
      `CSR_ADDR_MARCHID:       sel = SEL_MARCHID;
      `CSR_ADDR_MIMPID:        sel = SEL_MIMPID;
      `CSR_ADDR_MHARTID:       sel = SEL_MHARTID;
      default:                 sel = SEL_NONE;
    endcase
  end

  // Counter mirrors need their mcounteren bit below M
  always_comb begin
    case (sel)
      SEL_CYCLE, SEL_CYCLEH:     mirror_en = cnt_en_cy;
      SEL_INSTRET, SEL_INSTRETH: mirror_en = cnt_en_ir;
      default:                   mirror_en = 1'b1;
    endcase
  end

  assign ro_write   = (req_addr.f.access == 2'b11) && (req_op != CSR_READ);
  assign low_priv   = req_addr.f.priv > req_priv; // Priv field is the minimum level
  assign unknown    = (sel == SEL_NONE);
  assign cnt_denied = (req_priv != PRIV_M) && !mirror_en;

  assign illegal = ro_write | low_priv | unknown | cnt_denied;

endmodule

/* csr_defs.svh */
// CSR unit constants: widths, machine CSR addresses, reset values and write masks
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 12

// Machine trap setup
`define CSR_ADDR_MSTATUS       12'h300
`define CSR_ADDR_MIE           12'h304
`define CSR_ADDR_MTVEC         12'h305
`define CSR_ADDR_MCOUNTEREN    12'h306
`define CSR_ADDR_MCOUNTINHIBIT 12'h320

// Machine trap handling
`define CSR_ADDR_MSCRATCH      12'h340
`define CSR_ADDR_MEPC          12'h341
`define CSR_ADDR_MCAUSE        12'h342
`define CSR_ADDR_MTVAL         12'h343
`define CSR_ADDR_MIP           12'h344

// Machine counters, low and high halves
`define CSR_ADDR_MCYCLE        12'hB00
`define CSR_ADDR_MINSTRET      12'hB02
`define CSR_ADDR_MCYCLEH       12'hB80
`define CSR_ADDR_MINSTRETH     12'hB82

// User read-only counter mirrors
`define CSR_ADDR_CYCLE         12'hC00
`define CSR_ADDR_INSTRET       12'hC02
`define CSR_ADDR_CYCLEH        12'hC80
`define CSR_ADDR_INSTRETH      12'hC82

// Machine information
`define CSR_ADDR_MVENDORID     12'hF11
`define CSR_ADDR_MARCHID       12'hF12
`define CSR_ADDR_MIMPID        12'hF13
`define CSR_ADDR_MHARTID       12'hF14

`define CSR_MSTATUS_RST 32'h0020_0000 // tw set, mpp = U
`define CSR_MIE_MASK    32'h0000_0888 // msie, mtie, meie
`define CSR_CNT_MASK    32'h0000_0005 // cy and ir only

`endif

/* csr_execute.sv */
// CSR execute: machine register state, 64-bit counters and legalized CSR writes
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_execute
  import csr_pkg::*;
#(
  parameter int HART_ID = 0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        accept,
  input  csr_op_t     req_op,
  input  csr_word_t   req_wdata,
  input  csr_sel_t    sel,
  input  logic        illegal,
  input  csr_word_t   old_value,
  input  logic        inst_ret,
  output mstatus_t    mstatus,
  output csr_word_t   mtvec,
  output csr_word_t   mie,
  output csr_word_t   mip,
  output csr_word_t   mscratch,
  output csr_word_t   mepc,
  output csr_word_t   mcause,
  output csr_word_t   mtval,
  output csr_word_t   mcounteren,
  output csr_word_t   mcountinhibit,
  output logic [63:0] mcycle,
  output logic [63:0] minstret,
  output csr_word_t   mhartid,
  output logic        cnt_en_cy,
  output logic        cnt_en_ir
);

  csr_word_t cand;
  logic      commit;
  mstatus_t  mstatus_new;
  csr_word_t mtvec_new;
  logic      wr_cy_lo;
  logic      wr_cy_hi;
  logic      wr_ir_lo;
  logic      wr_ir_hi;

  // Half write wins over the increment, other half kept
  function automatic logic [63:0] count_next(input logic [63:0] cnt, input logic inc,
                                             input logic wr_lo, input logic wr_hi,
                                             input csr_word_t val);
    logic [63:0] nxt;
    nxt = cnt + {63'd0, inc};
    if (wr_lo) begin
      nxt = {cnt[63:32], val};
    end else if (wr_hi) begin
      nxt = {val, cnt[31:0]};
    end
    return nxt;
  endfunction

  always_comb begin
    case (req_op)
      CSR_SET:   cand = old_value | req_wdata;
      CSR_CLEAR: cand = old_value & ~req_wdata;
      default:   cand = req_wdata;
    endcase
  end

  assign commit = accept && !illegal && (req_op != CSR_READ);

  always_comb begin
    mstatus_new      = '0; // fs, vs, xs and sd stay zero
    mstatus_new.mie  = cand[3];
    mstatus_new.mpie = cand[7];
    mstatus_new.mprv = cand[17];
    mstatus_new.tw   = cand[21];
    mstatus_new.mpp  = (cand[12:11] == 2'b11) ? PRIV_M : PRIV_U; // S and reserved drop to U
  end

  // Modes 2 and 3 fall back to direct
  assign mtvec_new = {cand[31:2], cand[1] ? 2'b00 : cand[1:0]};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= mstatus_t'(`CSR_MSTATUS_RST);
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= `CSR_CNT_MASK; // U-mode counter reads open after reset
      mcountinhibit <= '0;
    end else if (commit) begin
      case (sel)
        SEL_MSTATUS:       mstatus       <= mstatus_new;
        SEL_MTVEC:         mtvec         <= mtvec_new;
        SEL_MIE:           mie           <= cand & `CSR_MIE_MASK;
        SEL_MIP:           mip           <= cand & `CSR_MIE_MASK;
        SEL_MSCRATCH:      mscratch      <= cand;
        SEL_MEPC:          mepc          <= cand;
        SEL_MCAUSE:        mcause        <= cand;
        SEL_MTVAL:         mtval         <= cand;
        SEL_MCOUNTEREN:    mcounteren    <= cand & `CSR_CNT_MASK;
        SEL_MCOUNTINHIBIT: mcountinhibit <= cand & `CSR_CNT_MASK;
        default: ; // Counters handled below, the rest are read-only
      endcase
    end
  end

  assign wr_cy_lo = commit && (sel == SEL_MCYCLE);
  assign wr_cy_hi = commit && (sel == SEL_MCYCLEH);
  assign wr_ir_lo = commit && (sel == SEL_MINSTRET);
  assign wr_ir_hi = commit && (sel == SEL_MINSTRETH);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle   <= count_next(mcycle, !mcountinhibit[0], wr_cy_lo, wr_cy_hi, cand);
      minstret <= count_next(minstret, inst_ret && !mcountinhibit[2], wr_ir_lo, wr_ir_hi,
                             cand);
    end
  end

  assign cnt_en_cy = mcounteren[0];
  assign cnt_en_ir = mcounteren[2];
  assign mhartid   = csr_word_t'(HART_ID);

endmodule

/* csr_golden.txt */
# name op addr operand priv(0=U,3=M) expected_rdata expected_illegal
# op: R read, W write, S set, C clear, T retire (operand = count); rdata - is not checked
scratch_wr      W 340 a5a5f00d 3 00000000 0
scratch_rd      R 340 00000000 3 a5a5f00d 0
epc_wr          W 341 80001234 3 00000000 0
epc_rd          R 341 00000000 3 80001234 0
cause_wr        W 342 8000000b 3 00000000 0
cause_rd        R 342 00000000 3 8000000b 0
scratch_set     S 340 0000000f 3 a5a5f00d 0
scratch_clr     C 340 a0a00000 3 a5a5f00f 0
scratch_chk     R 340 00000000 3 0505f00f 0
mstatus_wr      W 300 00026888 3 00200000 0
mstatus_rd      R 300 00000000 3 00020088 0
mtvec_wr        W 305 80000103 3 00000000 0
mtvec_rd        R 305 00000000 3 80000100 0
mie_wr          W 304 ffffffff 3 00000000 0
mie_rd          R 304 00000000 3 00000888 0
mip_set         S 344 ffffffff 3 00000000 0
mip_rd          R 344 00000000 3 00000888 0
cnten_wr        W 306 ffffffff 3 00000005 0
hartid_wr       W f14 00000001 3 00000000 1
hartid_rd       R f14 00000000 3 00000005 0
u_mscratch_rd   R 340 00000000 0 00000000 1
u_mscratch_wr   W 340 ffffffff 0 00000000 1
scratch_kept    R 340 00000000 3 0505f00f 0
unknown_rd      R 7c0 00000000 3 00000000 1
inhibit_wr      W 320 ffffffff 3 00000000 0
inhibit_rd      R 320 00000000 3 00000005 0
mcycle_wr       W b00 12345678 3 - 0
mcycleh_wr      W b80 000000ab 3 - 0
minstret_wr     W b02 fffffffe 3 00000000 0
minstreth_wr    W b82 00000010 3 00000000 0
mcycle_rd       R b00 00000000 3 12345678 0
mcycleh_rd      R b80 00000000 3 000000ab 0
minstret_rd     R b02 00000000 3 fffffffe 0
minstreth_rd    R b82 00000000 3 00000010 0
u_cycle_rd      R c00 00000000 0 12345678 0
cnten_clr       C 306 00000001 3 00000005 0
u_cycle_denied  R c00 00000000 0 00000000 1
u_instret_rd    R c02 00000000 0 fffffffe 0
inhibit_cy      W 320 00000001 3 00000005 0
retire_three    T 000 00000003 3 - 0
minstret_post   R b02 00000000 3 00000001 0
minstreth_post  R b82 00000000 3 00000011 0
mcycle_frozen   R b00 00000000 3 12345678 0

/* csr_pkg.sv */
// CSR package: operation, privilege, address, register select and mstatus types
`include "csr_defs.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0] csr_word_t;

  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  // 1 and 2 are reserved, both rank below M
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_level_t;

  typedef struct packed {
    logic [1:0] access; // 3 means read-only
    logic [1:0] priv;   // Lowest level allowed
    logic [7:0] index;
  } csr_addr_fields_t;

  typedef union packed {
    logic [`CSR_ADDR_W-1:0] raw;
    csr_addr_fields_t       f;
  } csr_addr_u;

  typedef enum logic [4:0] {
    SEL_NONE,
    SEL_MSTATUS, SEL_MIE, SEL_MTVEC, SEL_MCOUNTEREN, SEL_MCOUNTINHIBIT,
    SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
    SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
    SEL_CYCLE, SEL_CYCLEH, SEL_INSTRET, SEL_INSTRETH,
    SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID
  } csr_sel_t;

  // RV32 layout, S-mode bits folded into reserved fields
  typedef struct packed {
    logic        sd;         // 31
    logic [8:0]  reserved_4; // 30:22
    logic        tw;         // 21
    logic [2:0]  reserved_3; // 20:18
    logic        mprv;       // 17
    logic [1:0]  xs;         // 16:15
    logic [1:0]  fs;         // 14:13
    priv_level_t mpp;        // 12:11
    logic [1:0]  vs;         // 10:9
    logic        reserved_2; // 8
    logic        mpie;       // 7
    logic [2:0]  reserved_1; // 6:4
    logic        mie;        // 3
    logic [2:0]  reserved_0; // 2:0
  } mstatus_t;

endpackage

/* csr_result.sv */
// CSR result: old value read mux and the registered response
`timescale 1ns/1ps

module csr_result
  import csr_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  logic        accept,
  input  logic        rsp_ready,
  input  csr_sel_t    sel,
  input  logic        illegal,
  input  mstatus_t    mstatus,
  input  csr_word_t   mtvec,
  input  csr_word_t   mie,
  input  csr_word_t   mip,
  input  csr_word_t   mscratch,
  input  csr_word_t   mepc,
  input  csr_word_t   mcause,
  input  csr_word_t   mtval,
  input  csr_word_t   mcounteren,
  input  csr_word_t   mcountinhibit,
  input  logic [63:0] mcycle,
  input  logic [63:0] minstret,
  input  csr_word_t   mhartid,
  output csr_word_t   old_value,
  output logic        rsp_valid,
  output csr_word_t   rsp_rdata,
  output logic        rsp_illegal
);

  always_comb begin
    case (sel)
      SEL_MSTATUS:                 old_value = mstatus;
      SEL_MTVEC:                   old_value = mtvec;
      SEL_MIE:                     old_value = mie;
      SEL_MIP:                     old_value = mip;
      SEL_MSCRATCH:                old_value = mscratch;
      SEL_MEPC:                    old_value = mepc;
      SEL_MCAUSE:                  old_value = mcause;
      SEL_MTVAL:                   old_value = mtval;
      SEL_MCOUNTEREN:              old_value = mcounteren;
      SEL_MCOUNTINHIBIT:           old_value = mcountinhibit;
      SEL_MCYCLE, SEL_CYCLE:       old_value = mcycle[31:0];
      SEL_MCYCLEH, SEL_CYCLEH:     old_value = mcycle[63:32];
      SEL_MINSTRET, SEL_INSTRET:   old_value = minstret[31:0];
      SEL_MINSTRETH, SEL_INSTRETH: old_value = minstret[63:32];
      SEL_MHARTID:                 old_value = mhartid;
      SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID: begin
        old_value = '0; // Not implemented, reads as zero
      end
      default:                     old_value = '0;
    endcase
  end

  // New accept may replace a response consumed in the same cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      rsp_rdata   <= illegal ? '0 : old_value; // Faulting access returns zero
      rsp_illegal <= illegal;
    end
  end

endmodule

/* csr_unit.sv */
// CSR unit top: request/response handshake around decode, execute and result
`timescale 1ns/1ps

module csr_unit
  import csr_pkg::*;
#(
  parameter int HART_ID = 0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        req_valid,
  output logic        req_ready,
  input  csr_op_t     req_op,
  input  csr_addr_u   req_addr,
  input  csr_word_t   req_wdata,
  input  priv_level_t req_priv,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output csr_word_t   rsp_rdata,
  output logic        rsp_illegal,
  input  logic        inst_ret
);

  logic        accept;
  csr_sel_t    sel;
  logic        illegal;
  csr_word_t   old_value;
  logic        cnt_en_cy;
  logic        cnt_en_ir;
  mstatus_t    mstatus;
  csr_word_t   mtvec;
  csr_word_t   mie;
  csr_word_t   mip;
  csr_word_t   mscratch;
  csr_word_t   mepc;
  csr_word_t   mcause;
  csr_word_t   mtval;
  csr_word_t   mcounteren;
  csr_word_t   mcountinhibit;
  logic [63:0] mcycle;
  logic [63:0] minstret;
  csr_word_t   mhartid;

  // One response slot, refilled in the cycle it drains
  assign req_ready = !rsp_valid || rsp_ready;
  assign accept    = req_valid && req_ready;

  csr_decode i_decode (
    .req_op, .req_addr, .req_priv, .cnt_en_cy, .cnt_en_ir, .sel, .illegal
  );

  csr_execute #(.HART_ID(HART_ID)) i_execute (
    .CLK, .nRST, .accept, .req_op, .req_wdata, .sel, .illegal, .old_value, .inst_ret,
    .mstatus, .mtvec, .mie, .mip, .mscratch, .mepc, .mcause, .mtval,
    .mcounteren, .mcountinhibit, .mcycle, .minstret, .mhartid, .cnt_en_cy, .cnt_en_ir
  );

  csr_result i_result (
    .CLK, .nRST, .accept, .rsp_ready, .sel, .illegal,
    .mstatus, .mtvec, .mie, .mip, .mscratch, .mepc, .mcause, .mtval,
    .mcounteren, .mcountinhibit, .mcycle, .minstret, .mhartid,
    .old_value, .rsp_valid, .rsp_rdata, .rsp_illegal
  );

endmodule

/* list.f */
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_execute.sv
csr_result.sv
csr_unit.sv
csr_checker.sv
tb_csr_unit.sv

/* tb_csr_unit.sv */
// CSR unit testbench: replays golden request vectors under random response stalls
`timescale 1ns/1ps

module tb_csr_unit
  import csr_pkg::*;
();

  logic        CLK;
  logic        nRST;
  logic        req_valid;
  logic        req_ready;
  csr_op_t     req_op;
  csr_addr_u   req_addr;
  csr_word_t   req_wdata;
  priv_level_t req_priv;
  logic        rsp_valid;
  logic        rsp_ready;
  csr_word_t   rsp_rdata;
  logic        rsp_illegal;
  logic        inst_ret;

  // Golden vectors, one entry per file line
  string       v_name[$];
  csr_op_t     v_op[$];
  bit          v_retire[$];
  logic [11:0] v_addr[$];
  csr_word_t   v_wdata[$];
  priv_level_t v_priv[$];
  csr_word_t   v_rdata[$];
  bit          v_check_rdata[$];
  logic        v_illegal[$];

  int pending[$]; // Accepted vectors still owed a response
  int n_vec;
  int vec_idx;
  int retire_left;
  bit retiring;
  int cycle_count;
  int cycle_limit = 100;
  int word_errors;
  int flag_errors;
  int other_errors;

  csr_unit #(.HART_ID(5)) i_dut (
    .CLK, .nRST, .req_valid, .req_ready, .req_op, .req_addr, .req_wdata, .req_priv,
    .rsp_valid, .rsp_ready, .rsp_rdata, .rsp_illegal, .inst_ret
  );

  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("ERROR: DUT stopped responding, no progress after %0d cycles", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input csr_word_t expected,
                            input csr_word_t actual);
    if (actual !== expected) begin
      word_errors = word_errors + 1;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flag_errors = flag_errors + 1;
      $display("CHECK FAILED %s: expected illegal %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic load_golden(output bit ok);
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op_s;
    string       exp_s;
    logic [11:0] addr;
    csr_word_t   wdata;
    logic [1:0]  priv;
    csr_word_t   exp_data;
    logic        ill;
    ok = 1'b1;
    fd = $fopen("csr_golden.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open csr_golden.txt");
      ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%s %s %h %h %h %s %h", name, op_s, addr, wdata, priv, exp_s, ill);
        if (n != 7) begin
          $display("ERROR: malformed golden line: %s", line);
          ok = 1'b0;
          continue;
        end
        exp_data = '0;
        if (exp_s != "-") n = $sscanf(exp_s, "%h", exp_data); // Dash means data not checked
        case (op_s)
          "R", "T": v_op.push_back(CSR_READ);
          "W":      v_op.push_back(CSR_WRITE);
          "S":      v_op.push_back(CSR_SET);
          "C":      v_op.push_back(CSR_CLEAR);
          default: begin
            $display("ERROR: unknown op %s in golden line %s", op_s, name);
            ok = 1'b0;
            v_op.push_back(CSR_READ);
          end
        endcase
        v_name.push_back(name);
        v_retire.push_back(op_s == "T");
        v_addr.push_back(addr);
        v_wdata.push_back(wdata);
        v_priv.push_back(priv_level_t'(priv));
        v_rdata.push_back(exp_data);
        v_check_rdata.push_back(exp_s != "-");
        v_illegal.push_back(ill);
      end
      $fclose(fd);
    end
    n_vec = v_name.size();
  endtask

  // Runs 2 ns after the rising edge
  task automatic drive_inputs();
    req_valid = 1'b0;
    inst_ret  = 1'b0;
    rsp_ready = ($urandom % 4) != 0; // Stall roughly one cycle in four
    if (vec_idx < n_vec && v_retire[vec_idx]) begin
      if (pending.size() == 0) begin // Retire only with nothing in flight
        if (!retiring) begin
          retiring    = 1'b1;
          retire_left = int'(v_wdata[vec_idx]);
        end
        if (retire_left > 0) begin
          inst_ret    = 1'b1;
          retire_left = retire_left - 1;
        end else begin
          retiring = 1'b0;
          vec_idx  = vec_idx + 1;
        end
      end
    end else if (vec_idx < n_vec) begin
      req_valid    = 1'b1;
      req_op       = v_op[vec_idx];
      req_addr.raw = v_addr[vec_idx];
      req_wdata    = v_wdata[vec_idx];
      req_priv     = v_priv[vec_idx];
    end
  endtask

  // Runs at the falling edge, values hold until the next rising edge
  task automatic sample_outputs();
    int idx;
    if (rsp_valid && rsp_ready) begin
      if (pending.size() == 0) begin
        other_errors = other_errors + 1;
        $display("ERROR: response delivered with no request outstanding");
      end else begin
        idx = pending.pop_front();
        if (v_check_rdata[idx]) check_word(v_name[idx], v_rdata[idx], rsp_rdata);
        check_flag(v_name[idx], v_illegal[idx], rsp_illegal);
      end
    end
    if (req_valid && req_ready) begin
      pending.push_back(vec_idx);
      vec_idx = vec_idx + 1;
    end
  endtask

  task automatic report_result();
    int total;
    total = word_errors + flag_errors + other_errors + i_dut.i_checker.fail_count;
    $display("Errors: %0d data, %0d illegal flag, %0d protocol, %0d assertion",
             word_errors, flag_errors, other_errors, i_dut.i_checker.fail_count);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    CLK       = 1'b0;
    nRST      = 1'b0;
    req_valid = 1'b0;
    req_op    = CSR_READ;
    req_addr  = '0;
    req_wdata = '0;
    req_priv  = PRIV_M;
    rsp_ready = 1'b0;
    inst_ret  = 1'b0;
    void'($urandom(11));
    load_golden(ok);
    if (!ok) begin
      $display("ERROR: golden vectors could not be loaded");
      $display("test failed");
      $finish;
    end else begin
      cycle_limit = 20 * n_vec + 100;
      repeat (3) @(posedge CLK);
      #2;
      nRST = 1'b1;
      while (vec_idx < n_vec || pending.size() > 0) begin
        drive_inputs();
        @(negedge CLK);
        sample_outputs();
        @(posedge CLK);
        #2;
      end
      report_result();
    end
  end

endmodule
